// File: rtl/rf_settings.svh
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// ==============================
// Register file geometry
// ==============================
`define RF_DATA_WIDTH   32
`define RF_ADDR_WIDTH   6
`define RF_NUM_REGS     64
`define RF_TAG_WIDTH    2

// ==============================
// Bundle and buffering
// ==============================
// Instructions per dispatch bundle and commits per commit bundle
`define RF_ISSUE_WIDTH  3
`define RF_FIFO_DEPTH   4

`endif

// File: rtl/rf_pkg.sv
`default_nettype none

`include "rf_settings.svh"

package rf_pkg;

    // ==============================
    // Scalar types
    // ==============================
    typedef logic [`RF_DATA_WIDTH-1:0] data_t;
    typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`RF_TAG_WIDTH-1:0]  tag_t;

    // Tags 0..2 name the producing ALU and 3 marks ready data
    parameter tag_t TAG_VALID = 2'd3;

    // ==============================
    // Dispatch side
    // ==============================
    typedef struct packed {
        logic      alloc_en;
        reg_addr_t dest;
        tag_t      alu_tag;
        reg_addr_t src_a;
        reg_addr_t src_b;
    } dispatch_slot_t;

    // Index 0 is the oldest instruction
    typedef dispatch_slot_t [`RF_ISSUE_WIDTH-1:0] dispatch_bundle_t;

    // ==============================
    // Commit side
    // ==============================
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
    } commit_slot_t;

    typedef commit_slot_t [`RF_ISSUE_WIDTH-1:0] commit_bundle_t;

    // ==============================
    // Operand output
    // ==============================
    typedef struct packed {
        data_t data;
        tag_t  tag;
    } operand_t;

    // Entry 2*i is slot i source a and entry 2*i+1 is slot i source b
    typedef operand_t [2*`RF_ISSUE_WIDTH-1:0] operand_bundle_t;

endpackage

`default_nettype wire

// File: rtl/bundle_fifo.sv
`default_nettype none

`include "rf_settings.svh"

module bundle_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     head_valid,
    output payload_t head_data,
    input  logic     pop
);

    localparam int DEPTH   = `RF_FIFO_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];

    // A full FIFO still takes a new entry while the head leaves
    assign in_ready = (count != COUNT_W'(DEPTH)) || pop;
    assign do_push  = in_valid && in_ready;
    assign do_pop   = pop && head_valid;

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/tagged_register_file.sv
`default_nettype none

`include "rf_settings.svh"

module tagged_register_file (
    input  logic                     clk,
    input  logic                     reset,
    input  rf_pkg::dispatch_bundle_t reads,
    input  logic                     alloc_go,
    input  rf_pkg::commit_bundle_t   commits,
    input  logic                     commit_go,
    output rf_pkg::operand_bundle_t  operands
);

    localparam int ISSUE = `RF_ISSUE_WIDTH;
    localparam int PORTS = 2 * `RF_ISSUE_WIDTH;
    localparam int NREGS = `RF_NUM_REGS;

    rf_pkg::data_t    regs_data [NREGS];
    rf_pkg::tag_t     regs_tag  [NREGS];

    // Per slot qualifiers shared by the write and forwarding paths
    logic [ISSUE-1:0] alloc_live;
    logic [ISSUE-1:0] commit_live;

    always_comb begin
        for (int s = 0; s < ISSUE; s++) begin
            alloc_live[s]  = alloc_go && reads[s].alloc_en && (reads[s].dest != '0);
            commit_live[s] = commit_go && commits[s].en && (commits[s].addr != '0);
        end
    end

    // ==============================
    // Array update
    // ==============================
    // Allocations go first so a commit to the same register wins
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < NREGS; r++) begin
                regs_data[r] <= '0;
                regs_tag[r]  <= rf_pkg::TAG_VALID;
            end
        end else begin
            for (int s = 0; s < ISSUE; s++) begin
                if (alloc_live[s]) begin
                    regs_tag[reads[s].dest] <= reads[s].alu_tag;
                end
            end
            for (int c = 0; c < ISSUE; c++) begin
                if (commit_live[c]) begin
                    regs_data[commits[c].addr] <= commits[c].data;
                    regs_tag[commits[c].addr]  <= rf_pkg::TAG_VALID;
                end
            end
        end
    end

    // ==============================
    // Read ports with forwarding
    // ==============================
    // Sources are applied lowest priority first and each later match overrides
    always_comb begin
        rf_pkg::reg_addr_t addr;
        int                slot;

        for (int p = 0; p < PORTS; p++) begin
            slot = p / 2;
            addr = (p % 2 == 0) ? reads[slot].src_a : reads[slot].src_b;

            // Array contents
            operands[p].data = regs_data[addr];
            operands[p].tag  = regs_tag[addr];

            // Allocations of older slots with the nearest one last
            for (int s = 0; s < ISSUE; s++) begin
                if (s < slot && alloc_live[s] && reads[s].dest == addr) begin
                    operands[p].data = '0;
                    operands[p].tag  = reads[s].alu_tag;
                end
            end

            // Same cycle commits with the highest slot last
            for (int c = 0; c < ISSUE; c++) begin
                if (commit_live[c] && commits[c].addr == addr) begin
                    operands[p].data = commits[c].data;
                    operands[p].tag  = rf_pkg::TAG_VALID;
                end
            end

            // x0 reads as ready zero
            if (addr == '0) begin
                operands[p].data = '0;
                operands[p].tag  = rf_pkg::TAG_VALID;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/operand_stage.sv
`default_nettype none

module operand_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    head_valid,
    output logic                    take,
    input  rf_pkg::operand_bundle_t operands_in,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rf_pkg::operand_bundle_t operands_out
);

    // Load when empty or when the held bundle leaves this cycle
    assign take = head_valid && (!out_valid || out_ready);

    // Operand payload
    always_ff @(posedge clk) begin
        if (take) begin
            operands_out <= operands_in;
        end
    end

    // Output valid flag
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rf_subsystem_top.sv
`default_nettype none

module rf_subsystem_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    output logic                     dispatch_ready,
    input  rf_pkg::dispatch_bundle_t dispatch_in,
    input  logic                     commit_valid,
    output logic                     commit_ready,
    input  rf_pkg::commit_bundle_t   commit_in,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rf_pkg::operand_bundle_t  operands_out
);

    logic                     dispatch_head_valid;
    rf_pkg::dispatch_bundle_t dispatch_head;
    logic                     commit_head_valid;
    rf_pkg::commit_bundle_t   commit_head;
    rf_pkg::operand_bundle_t  rf_operands;
    logic                     take;

    // ==============================
    // Input buffers
    // ==============================
    bundle_fifo #(
        .payload_t (rf_pkg::dispatch_bundle_t)
    ) u_dispatch_fifo (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (dispatch_valid),
        .in_ready   (dispatch_ready),
        .in_data    (dispatch_in),
        .head_valid (dispatch_head_valid),
        .head_data  (dispatch_head),
        .pop        (take)
    );

    // Commits never stall so the head leaves as soon as it shows up
    bundle_fifo #(
        .payload_t (rf_pkg::commit_bundle_t)
    ) u_commit_fifo (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (commit_valid),
        .in_ready   (commit_ready),
        .in_data    (commit_in),
        .head_valid (commit_head_valid),
        .head_data  (commit_head),
        .pop        (commit_head_valid)
    );

    // ==============================
    // Register file and output
    // ==============================
    // Allocation lands in the same cycle the bundle is read
    tagged_register_file u_regfile (
        .clk       (clk),
        .reset     (reset),
        .reads     (dispatch_head),
        .alloc_go  (take),
        .commits   (commit_head),
        .commit_go (commit_head_valid),
        .operands  (rf_operands)
    );

    operand_stage u_operand_stage (
        .clk          (clk),
        .reset        (reset),
        .head_valid   (dispatch_head_valid),
        .take         (take),
        .operands_in  (rf_operands),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .operands_out (operands_out)
    );

endmodule

`default_nettype wire

// File: verification/tb_rf_subsystem.sv
`default_nettype none

`include "rf_settings.svh"

module tb_rf_subsystem;

    logic                     clk;
    logic                     reset;
    logic                     dispatch_valid;
    logic                     dispatch_ready;
    rf_pkg::dispatch_bundle_t dispatch_in;
    logic                     commit_valid;
    logic                     commit_ready;
    rf_pkg::commit_bundle_t   commit_in;
    logic                     out_valid;
    logic                     out_ready;
    rf_pkg::operand_bundle_t  operands_out;

    rf_subsystem_top u_rf_subsystem_top (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_in    (dispatch_in),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_in      (commit_in),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .operands_out   (operands_out)
    );

    always #10 clk = ~clk;

    // ==============================
    // Reference model and table
    // ==============================
    rf_pkg::data_t            model_data [`RF_NUM_REGS];
    rf_pkg::tag_t             model_tag  [`RF_NUM_REGS];
    string                    names      [16];
    logic                     has_commit [16];
    rf_pkg::commit_bundle_t   commit_tab [16];
    rf_pkg::dispatch_bundle_t disp_tab   [16];
    int                       stall_tab  [16];
    rf_pkg::operand_bundle_t  exp_tab    [16];
    int                       n_entries;
    logic [31:0]              lfsr;
    int                       err_cnt;
    int                       pass_cnt;
    int                       fail_cnt;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic rf_pkg::reg_addr_t rand_reg();
        rf_pkg::reg_addr_t r;
        r = rf_pkg::reg_addr_t'(rand_bits(`RF_ADDR_WIDTH));
        if (r == '0) begin
            r = 6'd1;
        end
        return r;
    endfunction

    function automatic rf_pkg::dispatch_slot_t make_slot(input logic alloc, input int dest,
                                                        input int tag, input int a, input int b);
        rf_pkg::dispatch_slot_t s;
        s.alloc_en = alloc;
        s.dest     = rf_pkg::reg_addr_t'(dest);
        s.alu_tag  = rf_pkg::tag_t'(tag);
        s.src_a    = rf_pkg::reg_addr_t'(a);
        s.src_b    = rf_pkg::reg_addr_t'(b);
        return s;
    endfunction

    function automatic rf_pkg::commit_slot_t make_commit(input logic en, input int addr,
                                                        input rf_pkg::data_t data);
        rf_pkg::commit_slot_t c;
        c.en   = en;
        c.addr = rf_pkg::reg_addr_t'(addr);
        c.data = data;
        return c;
    endfunction

    // Expected operands by the read priority rules followed by the model update
    task automatic predict(input logic hc, input rf_pkg::commit_bundle_t cb,
                           input rf_pkg::dispatch_bundle_t db,
                           output rf_pkg::operand_bundle_t ob);
        rf_pkg::reg_addr_t addr;
        int                slot;
        logic              hit;
        for (int p = 0; p < 2 * `RF_ISSUE_WIDTH; p++) begin
            slot = p / 2;
            addr = (p % 2 == 0) ? db[slot].src_a : db[slot].src_b;
            hit  = 1'b0;
            if (addr == '0) begin
                ob[p].data = '0;
                ob[p].tag  = rf_pkg::TAG_VALID;
                hit        = 1'b1;
            end
            for (int c = `RF_ISSUE_WIDTH - 1; c >= 0; c--) begin
                if (!hit && hc && cb[c].en && cb[c].addr == addr) begin
                    ob[p].data = cb[c].data;
                    ob[p].tag  = rf_pkg::TAG_VALID;
                    hit        = 1'b1;
                end
            end
            for (int s = slot - 1; s >= 0; s--) begin
                if (!hit && db[s].alloc_en && db[s].dest == addr) begin
                    ob[p].data = '0;
                    ob[p].tag  = db[s].alu_tag;
                    hit        = 1'b1;
                end
            end
            if (!hit) begin
                ob[p].data = model_data[addr];
                ob[p].tag  = model_tag[addr];
            end
        end
        for (int s = 0; s < `RF_ISSUE_WIDTH; s++) begin
            if (db[s].alloc_en && db[s].dest != '0) begin
                model_tag[db[s].dest] = db[s].alu_tag;
            end
        end
        for (int c = 0; c < `RF_ISSUE_WIDTH; c++) begin
            if (hc && cb[c].en && cb[c].addr != '0) begin
                model_data[cb[c].addr] = cb[c].data;
                model_tag[cb[c].addr]  = rf_pkg::TAG_VALID;
            end
        end
    endtask

    task automatic add_entry(input string name, input logic hc, input rf_pkg::commit_bundle_t cb,
                             input rf_pkg::dispatch_bundle_t db, input int stall);
        names[n_entries]      = name;
        has_commit[n_entries] = hc;
        commit_tab[n_entries] = cb;
        disp_tab[n_entries]   = db;
        stall_tab[n_entries]  = stall;
        predict(hc, cb, db, exp_tab[n_entries]);
        n_entries++;
    endtask

    // ==============================
    // Checks and waits
    // ==============================
    task automatic compare_operands(input rf_pkg::operand_bundle_t exp);
        for (int p = 0; p < 2 * `RF_ISSUE_WIDTH; p++) begin
            if (operands_out[p].data !== exp[p].data) begin
                $display("ERR %0t operands_out[%0d].data exp %h got %h",
                         $time, p, exp[p].data, operands_out[p].data);
                err_cnt++;
            end
            if (operands_out[p].tag !== exp[p].tag) begin
                $display("ERR %0t operands_out[%0d].tag exp %0d got %0d",
                         $time, p, exp[p].tag, operands_out[p].tag);
                err_cnt++;
            end
        end
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!out_valid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("Timeout waiting for out_valid at %0t", $time);
            err_cnt++;
        end
    endtask

    task automatic wait_input_ready();
        int n;
        n = 0;
        while (!(dispatch_ready && commit_ready) && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!(dispatch_ready && commit_ready)) begin
            $display("Timeout waiting for dispatch_ready and commit_ready at %0t", $time);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name);
        if (err_cnt == 0) begin
            $display("%-16s pass", name);
            pass_cnt++;
        end else begin
            $display("%-16s fail (%0d errors)", name, err_cnt);
            fail_cnt++;
        end
        err_cnt = 0;
    endtask

    // One table entry through the DUT
    task automatic apply_entry(input int i);
        wait_input_ready();
        dispatch_in    = disp_tab[i];
        dispatch_valid = 1'b1;
        commit_in      = commit_tab[i];
        commit_valid   = has_commit[i];
        out_ready      = (stall_tab[i] == 0);
        @(negedge clk);
        dispatch_valid = 1'b0;
        commit_valid   = 1'b0;
        wait_out_valid();
        // Bundle must hold while stalled
        for (int s = 0; s < stall_tab[i]; s++) begin
            if (!out_valid) begin
                $display("ERR %0t out_valid exp 1 got 0", $time);
                err_cnt++;
            end
            compare_operands(exp_tab[i]);
            @(negedge clk);
        end
        out_ready = 1'b1;
        compare_operands(exp_tab[i]);
        repeat (4) @(negedge clk);
        if (out_valid) begin
            $display("Operand bundle still valid after it was accepted at %0t", $time);
            err_cnt++;
        end
        report_test(names[i]);
    endtask

    // Fill the dispatch FIFO against a stalled consumer, then drain it
    task automatic back_pressure(input int base);
        rf_pkg::operand_bundle_t  exp_q[$];
        rf_pkg::dispatch_bundle_t db;
        rf_pkg::operand_bundle_t  ob;
        int                       n;
        int                       got;
        out_ready = 1'b0;
        n = 0;
        while (dispatch_ready && n < 16) begin
            for (int s = 0; s < `RF_ISSUE_WIDTH; s++) begin
                db[s] = make_slot(1'b0, 0, 0, int'(rand_reg()), int'(rand_reg()));
            end
            // Slot 0 reads a different pair of committed registers in each bundle
            db[0].src_a = rf_pkg::reg_addr_t'(base + n % 3);
            db[0].src_b = rf_pkg::reg_addr_t'(base + (n / 3) % 3);
            predict(1'b0, '0, db, ob);
            exp_q.push_back(ob);
            dispatch_in    = db;
            dispatch_valid = 1'b1;
            @(negedge clk);
            dispatch_valid = 1'b0;
            if (out_valid) begin
                compare_operands(exp_q[0]);
            end
            n++;
        end
        if (dispatch_ready) begin
            $display("dispatch_ready never fell while the output was stalled");
            err_cnt++;
        end
        out_ready = 1'b1;
        got = 0;
        n = 0;
        while (got < exp_q.size() && n < 100) begin
            if (out_valid) begin
                compare_operands(exp_q[got]);
                got++;
            end
            @(negedge clk);
            n++;
        end
        if (got != exp_q.size()) begin
            $display("Timeout draining bundles, got %0d of %0d", got, exp_q.size());
            err_cnt++;
        end
        if (out_valid) begin
            $display("Extra operand bundle after the drain at %0t", $time);
            err_cnt++;
        end
        report_test("back_pressure");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    rf_pkg::dispatch_bundle_t db;
    rf_pkg::commit_bundle_t   cb;
    int                       cbase;
    int                       a0;
    int                       x;
    rf_pkg::data_t            d0;
    rf_pkg::data_t            d1;
    rf_pkg::data_t            d2;

    initial begin
        clk            = 1'b0;
        reset          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_in    = '0;
        commit_valid   = 1'b0;
        commit_in      = '0;
        out_ready      = 1'b1;
        lfsr           = 32'h5cbc_7a38;
        n_entries      = 0;
        err_cnt        = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            model_data[r] = '0;
            model_tag[r]  = rf_pkg::TAG_VALID;
        end

        for (int s = 0; s < `RF_ISSUE_WIDTH; s++) begin
            db[s] = make_slot(1'b0, 0, 0, int'(rand_reg()), int'(rand_reg()));
        end
        add_entry("reset_state", 1'b0, '0, db, 0);

        // Three consecutive registers starting at 1..60
        cbase = 1 + int'(rand_bits(8) % 60);
        d0 = rand_bits(32);
        d1 = rand_bits(32);
        d2 = rand_bits(32);
        cb = {make_commit(1'b1, cbase + 2, d2), make_commit(1'b1, cbase + 1, d1),
              make_commit(1'b1, cbase, d0)};
        add_entry("commit_write", 1'b1, cb, '0, 0);
        db = {make_slot(1'b0, 0, 0, cbase, cbase + 1), make_slot(1'b0, 0, 0, cbase + 2, 0),
              make_slot(1'b0, 0, 0, cbase, cbase + 1)};
        add_entry("commit_read", 1'b0, '0, db, 0);
        cb = {make_commit(1'b0, 0, '0), make_commit(1'b0, 0, '0),
              make_commit(1'b1, 0, rand_bits(32))};
        add_entry("commit_reg0", 1'b1, cb, '0, 0);
        add_entry("reg0_read", 1'b0, '0, '0, 0);

        // Allocation within and across bundles
        a0 = 1 + int'(rand_bits(8) % 20);
        db = {make_slot(1'b1, a0 + 40, 2, a0 + 20, a0), make_slot(1'b1, a0 + 20, 1, a0, a0 + 40),
              make_slot(1'b1, a0, 0, a0, a0 + 20)};
        add_entry("alloc_bundle", 1'b0, '0, db, 0);
        db = {make_slot(1'b0, 0, 0, a0 + 40, 0), make_slot(1'b0, 0, 0, a0 + 20, a0 + 40),
              make_slot(1'b0, 0, 0, a0, a0 + 20)};
        add_entry("alloc_read", 1'b0, '0, db, 2);

        // Commits to x in slots 0 and 2 and to x+31 in slot 1 override their allocations
        x = 1 + int'(rand_bits(8) % 30);
        d0 = rand_bits(32);
        d1 = rand_bits(32);
        d2 = rand_bits(32);
        cb = {make_commit(1'b1, x, d2), make_commit(1'b1, x + 31, d1),
              make_commit(1'b1, x, d0)};
        db = {make_slot(1'b1, x, 2, x, x + 31), make_slot(1'b0, 0, 0, x + 31, x),
              make_slot(1'b1, x + 31, 1, x, x + 31)};
        add_entry("commit_forward", 1'b1, cb, db, 0);
        db = {make_slot(1'b0, 0, 0, x, x + 31), make_slot(1'b0, 0, 0, x + 31, x),
              make_slot(1'b0, 0, 0, x, 0)};
        add_entry("forward_read", 1'b0, '0, db, 3);

        repeat (10) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        back_pressure(cbase);

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: superscalar_rf.f
+incdir+rtl
rtl/rf_pkg.sv
rtl/bundle_fifo.sv
rtl/tagged_register_file.sv
rtl/operand_stage.sv
rtl/rf_subsystem_top.sv
verification/tb_rf_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register file subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f superscalar_rf.f --top-module tb_rf_subsystem -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1
